/* source/l1_trigger_pkg.sv */
`default_nettype none

package l1_trigger_pkg;

    localparam int NCHAN      = 4;
    localparam int NBEAMS     = 2;
    localparam int SAMPLE_W   = 12;
    localparam int SUM_W      = SAMPLE_W + 2;   // Room for four signed samples
    localparam int POWER_W    = 27;
    localparam int THRESH_W   = 28;
    localparam int MAX_DELAY  = 3;
    localparam int REG_ADDR_W = 3;

    // Delay in beats per beam and channel
    localparam int BEAM_DELAYS [NBEAMS][NCHAN] = '{
        '{0, 0, 0, 0},      // Broadside
        '{0, 1, 2, 3}       // One beat of tilt per channel
    };

    localparam logic [REG_ADDR_W-1:0] ADDR_THRESH0   = 3'd0;
    localparam logic [REG_ADDR_W-1:0] ADDR_THRESH1   = 3'd1;
    localparam logic [REG_ADDR_W-1:0] ADDR_SERVO_CFG = 3'd4;
    localparam logic [REG_ADDR_W-1:0] ADDR_PERIODS   = 3'd5;  // Read only

    // One register word, seen as a threshold or as the servo settings
    typedef union packed {
        struct packed {
            logic [31-THRESH_W:0] unused;
            logic [THRESH_W-1:0]  value;
        } thresh;
        struct packed {
            logic       enable;
            logic [6:0] unused;
            logic [7:0] kp;       // Step per correction
            logic [7:0] margin;   // Dead band around target
            logic [7:0] target;   // Triggers wanted per period
        } cfg;
    } reg_word_u;

endpackage

`default_nettype wire

/* source/beam_power.sv */
`default_nettype none

module beam_power (
    input  logic wbclk_i,
    input  logic rst_n_i,
    input  logic sample_valid_i,
    output logic sample_ready_o,
    input  logic [l1_trigger_pkg::NCHAN*l1_trigger_pkg::SAMPLE_W-1:0] sample_data_i,
    output logic pow_valid_o,
    input  logic pow_ready_i,
    output logic [l1_trigger_pkg::NBEAMS*l1_trigger_pkg::POWER_W-1:0] pow_data_o
);
    import l1_trigger_pkg::*;

    logic run_q;        // Low for the reset cycles
    logic accept;
    logic sum_adv;
    logic pow_adv;
    logic sum_valid_q;
    logic pow_valid_q;

    // Past samples per channel, index 0 is one beat old
    logic signed [SAMPLE_W-1:0] hist_q [NCHAN][MAX_DELAY];
    logic signed [SAMPLE_W-1:0] tap [NCHAN][MAX_DELAY+1];

    logic signed [SUM_W-1:0]     sum_d [NBEAMS];
    logic signed [SUM_W-1:0]     sum_q [NBEAMS];
    logic signed [2*SUM_W-1:0]   prod [NBEAMS];
    logic [NBEAMS-1:0][POWER_W-1:0] pow_q;

    // Stall chain
    assign pow_adv        = !pow_valid_q || pow_ready_i;
    assign sum_adv        = !sum_valid_q || pow_adv;
    assign sample_ready_o = run_q && sum_adv;
    assign accept         = sample_valid_i && sample_ready_o;

    always_comb begin
        for (int c = 0; c < NCHAN; c++) begin
            tap[c][0] = sample_data_i[c*SAMPLE_W +: SAMPLE_W];
            for (int d = 1; d <= MAX_DELAY; d++) begin
                tap[c][d] = hist_q[c][d-1];
            end
        end
    end

    // Delayed sum per beam, sign extended before adding
    always_comb begin
        for (int b = 0; b < NBEAMS; b++) begin
            sum_d[b] = '0;
            for (int c = 0; c < NCHAN; c++) begin
                sum_d[b] = sum_d[b] + {{(SUM_W-SAMPLE_W){tap[c][BEAM_DELAYS[b][c]][SAMPLE_W-1]}},
                                       tap[c][BEAM_DELAYS[b][c]]};
            end
        end
    end

    always_comb begin
        for (int b = 0; b < NBEAMS; b++) begin
            prod[b] = sum_q[b] * sum_q[b];  // Never negative, top bit unused
        end
    end

    always_ff @(posedge wbclk_i) begin
        if (!rst_n_i) begin
            run_q       <= 1'b0;
            sum_valid_q <= 1'b0;
            pow_valid_q <= 1'b0;
            for (int c = 0; c < NCHAN; c++) begin
                for (int d = 0; d < MAX_DELAY; d++) begin
                    hist_q[c][d] <= '0;
                end
            end
        end else begin
            run_q <= 1'b1;
            if (sum_adv) begin
                sum_valid_q <= accept;
            end
            if (pow_adv) begin
                pow_valid_q <= sum_valid_q;
            end
            if (accept) begin
                for (int c = 0; c < NCHAN; c++) begin
                    hist_q[c][0] <= tap[c][0];
                    for (int d = 1; d < MAX_DELAY; d++) begin
                        hist_q[c][d] <= hist_q[c][d-1];
                    end
                end
            end
        end
    end

    always_ff @(posedge wbclk_i) begin
        if (accept) begin
            sum_q <= sum_d;
        end
        if (pow_adv && sum_valid_q) begin
            for (int b = 0; b < NBEAMS; b++) begin
                pow_q[b] <= prod[b][POWER_W-1:0];
            end
        end
    end

    assign pow_valid_o = pow_valid_q;
    assign pow_data_o  = pow_q;

    // Source must hold its beat until it is taken
    a_sample_stable: assert property (@(posedge wbclk_i) disable iff (!rst_n_i)
        sample_valid_i && !sample_ready_o |=> !sample_valid_i || $stable(sample_data_i));

endmodule

`default_nettype wire

/* source/threshold_servo.sv */
`default_nettype none

module threshold_servo #(
    parameter int PERIOD_BEATS = 3750
) (
    input  logic wbclk_i,
    input  logic rst_n_i,
    input  logic hit_valid_i,
    input  logic [l1_trigger_pkg::NBEAMS-1:0] hit_beams_i,
    output logic [l1_trigger_pkg::NBEAMS*l1_trigger_pkg::THRESH_W-1:0] thresh_o,
    input  logic reg_valid_i,
    output logic reg_ready_o,
    input  logic reg_write_i,
    input  logic [l1_trigger_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [31:0] reg_wdata_i,
    output logic rsp_valid_o,
    input  logic rsp_ready_i,
    output logic [31:0] rsp_rdata_o
);
    import l1_trigger_pkg::*;

    localparam int CNT_W = $clog2(PERIOD_BEATS + 1);
    localparam logic [REG_ADDR_W-1:0] THRESH_ADDR [NBEAMS] = '{ADDR_THRESH0, ADDR_THRESH1};

    logic req_fire;
    logic wr_fire;
    reg_word_u wr_word;
    reg_word_u rd_word;
    logic rsp_valid_q;
    logic [31:0] rsp_rdata_q;

    logic [NBEAMS-1:0][THRESH_W-1:0] thresh_q;
    logic [NBEAMS-1:0][THRESH_W-1:0] thresh_corr;
    logic       cfg_en_q;
    logic [7:0] cfg_kp_q;
    logic [7:0] cfg_margin_q;
    logic [7:0] cfg_target_q;
    logic [31:0] periods_q;

    logic [CNT_W-1:0] beat_cnt_q;
    logic [NBEAMS-1:0][CNT_W-1:0] trig_cnt_q;
    logic [NBEAMS-1:0][CNT_W-1:0] last_cnt_q;  // Counts of the period just ended
    logic period_end;
    logic corr_q;                               // One cycle after period end

    logic [8:0] upper;
    logic [7:0] lower;
    logic [THRESH_W-1:0] kp_ext;

    assign reg_ready_o = !rsp_valid_q;          // One outstanding request
    assign req_fire    = reg_valid_i && reg_ready_o;
    assign wr_fire     = req_fire && reg_write_i;
    assign wr_word     = reg_wdata_i;

    always_comb begin
        rd_word = '0;
        for (int b = 0; b < NBEAMS; b++) begin
            if (reg_addr_i == THRESH_ADDR[b]) begin
                rd_word.thresh.value = thresh_q[b];
            end
        end
        if (reg_addr_i == ADDR_SERVO_CFG) begin
            rd_word.cfg.enable = cfg_en_q;
            rd_word.cfg.kp     = cfg_kp_q;
            rd_word.cfg.margin = cfg_margin_q;
            rd_word.cfg.target = cfg_target_q;
        end
        if (reg_addr_i == ADDR_PERIODS) begin
            rd_word = periods_q;
        end
    end

    always_ff @(posedge wbclk_i) begin
        if (!rst_n_i) begin
            rsp_valid_q <= 1'b0;
        end else if (req_fire) begin
            rsp_valid_q <= 1'b1;
        end else if (rsp_ready_i) begin
            rsp_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge wbclk_i) begin
        if (req_fire) begin
            rsp_rdata_q <= reg_write_i ? reg_wdata_i : rd_word;  // Writes echo the data
        end
    end

    // Period bookkeeping, one step per word taken downstream
    assign period_end = hit_valid_i && (beat_cnt_q == CNT_W'(PERIOD_BEATS - 1));

    always_ff @(posedge wbclk_i) begin
        if (!rst_n_i) begin
            beat_cnt_q <= '0;
            trig_cnt_q <= '0;
            last_cnt_q <= '0;
            periods_q  <= '0;
            corr_q     <= 1'b0;
        end else begin
            corr_q <= period_end;
            if (period_end) begin
                beat_cnt_q <= '0;
                trig_cnt_q <= '0;
                periods_q  <= periods_q + 32'd1;
                for (int b = 0; b < NBEAMS; b++) begin
                    last_cnt_q[b] <= trig_cnt_q[b] + CNT_W'(hit_beams_i[b]);
                end
            end else if (hit_valid_i) begin
                beat_cnt_q <= beat_cnt_q + 1'b1;
                for (int b = 0; b < NBEAMS; b++) begin
                    trig_cnt_q[b] <= trig_cnt_q[b] + CNT_W'(hit_beams_i[b]);
                end
            end
        end
    end

    // Dead band, lower edge clamps at zero
    assign upper  = {1'b0, cfg_target_q} + {1'b0, cfg_margin_q};
    assign lower  = (cfg_margin_q > cfg_target_q) ? 8'd0 : cfg_target_q - cfg_margin_q;
    assign kp_ext = THRESH_W'(cfg_kp_q);

    always_comb begin
        logic [THRESH_W:0] raised;
        for (int b = 0; b < NBEAMS; b++) begin
            raised = {1'b0, thresh_q[b]} + {1'b0, kp_ext};
            thresh_corr[b] = thresh_q[b];
            if (32'(last_cnt_q[b]) > 32'(upper)) begin
                thresh_corr[b] = raised[THRESH_W] ? '1 : raised[THRESH_W-1:0];
            end else if (32'(last_cnt_q[b]) < 32'(lower)) begin
                thresh_corr[b] = (thresh_q[b] < kp_ext) ? '0 : thresh_q[b] - kp_ext;
            end
        end
    end

    always_ff @(posedge wbclk_i) begin
        if (!rst_n_i) begin
            thresh_q     <= '1;     // Nothing triggers until configured
            cfg_en_q     <= 1'b0;
            cfg_kp_q     <= '0;
            cfg_margin_q <= '0;
            cfg_target_q <= '0;
        end else begin
            for (int b = 0; b < NBEAMS; b++) begin
                if (corr_q && cfg_en_q) begin
                    thresh_q[b] <= thresh_corr[b];
                end
                if (wr_fire && reg_addr_i == THRESH_ADDR[b]) begin
                    thresh_q[b] <= wr_word.thresh.value;   // Write beats correction
                end
            end
            if (wr_fire && reg_addr_i == ADDR_SERVO_CFG) begin
                cfg_en_q     <= wr_word.cfg.enable;
                cfg_kp_q     <= wr_word.cfg.kp;
                cfg_margin_q <= wr_word.cfg.margin;
                cfg_target_q <= wr_word.cfg.target;
            end
        end
    end

    assign thresh_o    = thresh_q;
    assign rsp_valid_o = rsp_valid_q;
    assign rsp_rdata_o = rsp_rdata_q;

    // A stalled response holds its data and blocks the next request
    a_one_outstanding: assert property (@(posedge wbclk_i) disable iff (!rst_n_i)
        rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_rdata_o));

    // Trigger path stays quiet through reset
    a_no_hit_in_reset: assert property (@(posedge wbclk_i)
        $past(!rst_n_i) && !rst_n_i |-> !hit_valid_i);

endmodule

`default_nettype wire

/* source/trigger_decide.sv */
`default_nettype none

module trigger_decide (
    input  logic wbclk_i,
    input  logic rst_n_i,
    input  logic pow_valid_i,
    output logic pow_ready_o,
    input  logic [l1_trigger_pkg::NBEAMS*l1_trigger_pkg::POWER_W-1:0] pow_data_i,
    input  logic [l1_trigger_pkg::NBEAMS*l1_trigger_pkg::THRESH_W-1:0] thresh_i,
    output logic trig_valid_o,
    input  logic trig_ready_i,
    output logic [l1_trigger_pkg::NBEAMS-1:0] trig_beams_o,
    output logic hit_valid_o,
    output logic [l1_trigger_pkg::NBEAMS-1:0] hit_beams_o
);
    import l1_trigger_pkg::*;

    logic trig_valid_q;
    logic [NBEAMS-1:0] trig_beams_q;
    logic [NBEAMS-1:0] above;
    logic load;

    // Strictly greater, power zero extended to threshold width
    always_comb begin
        for (int b = 0; b < NBEAMS; b++) begin
            above[b] = {1'b0, pow_data_i[b*POWER_W +: POWER_W]} > thresh_i[b*THRESH_W +: THRESH_W];
        end
    end

    assign pow_ready_o = !trig_valid_q || trig_ready_i;
    assign load        = pow_valid_i && pow_ready_o;

    always_ff @(posedge wbclk_i) begin
        if (!rst_n_i) begin
            trig_valid_q <= 1'b0;
        end else if (load) begin
            trig_valid_q <= 1'b1;
        end else if (trig_ready_i) begin
            trig_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge wbclk_i) begin
        if (load) begin
            trig_beams_q <= above;
        end
    end

    assign trig_valid_o = trig_valid_q;
    assign trig_beams_o = trig_beams_q;

    // Servo counts only what actually left
    assign hit_valid_o = trig_valid_q && trig_ready_i;
    assign hit_beams_o = trig_beams_q;

    a_trig_hold: assert property (@(posedge wbclk_i) disable iff (!rst_n_i)
        trig_valid_o && !trig_ready_i |=> trig_valid_o && $stable(trig_beams_o));

endmodule

`default_nettype wire

/* source/l1_trigger_top.sv */
`default_nettype none

module l1_trigger_top #(
    parameter int PERIOD_BEATS = 3750   // Beats per servo period
) (
    input  logic wbclk,
    input  logic rst_n_i,
    input  logic sample_valid_i,
    output logic sample_ready_o,
    input  logic [l1_trigger_pkg::NCHAN*l1_trigger_pkg::SAMPLE_W-1:0] sample_data_i,
    output logic trig_valid_o,
    input  logic trig_ready_i,
    output logic [l1_trigger_pkg::NBEAMS-1:0] trig_beams_o,
    input  logic reg_valid_i,
    output logic reg_ready_o,
    input  logic reg_write_i,
    input  logic [l1_trigger_pkg::REG_ADDR_W-1:0] reg_addr_i,
    input  logic [31:0] reg_wdata_i,
    output logic rsp_valid_o,
    input  logic rsp_ready_i,
    output logic [31:0] rsp_rdata_o
);
    import l1_trigger_pkg::*;

    logic pow_valid;
    logic pow_ready;
    logic [NBEAMS*POWER_W-1:0]  pow_data;
    logic [NBEAMS*THRESH_W-1:0] thresholds;
    logic hit_valid;
    logic [NBEAMS-1:0] hit_beams;

    beam_power u_beam_power (
        .wbclk_i        (wbclk),
        .rst_n_i        (rst_n_i),
        .sample_valid_i (sample_valid_i),
        .sample_ready_o (sample_ready_o),
        .sample_data_i  (sample_data_i),
        .pow_valid_o    (pow_valid),
        .pow_ready_i    (pow_ready),
        .pow_data_o     (pow_data)
    );

    trigger_decide u_trigger_decide (
        .wbclk_i      (wbclk),
        .rst_n_i      (rst_n_i),
        .pow_valid_i  (pow_valid),
        .pow_ready_o  (pow_ready),
        .pow_data_i   (pow_data),
        .thresh_i     (thresholds),
        .trig_valid_o (trig_valid_o),
        .trig_ready_i (trig_ready_i),
        .trig_beams_o (trig_beams_o),
        .hit_valid_o  (hit_valid),
        .hit_beams_o  (hit_beams)
    );

    threshold_servo #(
        .PERIOD_BEATS (PERIOD_BEATS)
    ) u_threshold_servo (
        .wbclk_i     (wbclk),
        .rst_n_i     (rst_n_i),
        .hit_valid_i (hit_valid),
        .hit_beams_i (hit_beams),
        .thresh_o    (thresholds),
        .reg_valid_i (reg_valid_i),
        .reg_ready_o (reg_ready_o),
        .reg_write_i (reg_write_i),
        .reg_addr_i  (reg_addr_i),
        .reg_wdata_i (reg_wdata_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_ready_i (rsp_ready_i),
        .rsp_rdata_o (rsp_rdata_o)
    );

endmodule

`default_nettype wire

/* sim/l1_trigger_tb.sv */
`default_nettype none

module l1_trigger_tb;
    import l1_trigger_pkg::*;

    localparam int TIMEOUT = 200;   // Cycles allowed for any single wait

    logic wbclk;
    logic rst_n_i;
    logic sample_valid_i;
    logic sample_ready_o;
    logic [NCHAN*SAMPLE_W-1:0] sample_data_i;
    logic trig_valid_o;
    logic trig_ready_i;
    logic [NBEAMS-1:0] trig_beams_o;
    logic reg_valid_i;
    logic reg_ready_o;
    logic reg_write_i;
    logic [REG_ADDR_W-1:0] reg_addr_i;
    logic [31:0] reg_wdata_i;
    logic rsp_valid_o;
    logic rsp_ready_i;
    logic [31:0] rsp_rdata_o;

    logic [NBEAMS-1:0] exp_q [$];   // Expected words of beats already sent
    int sent_cnt = 0;
    int got_cnt  = 0;

    l1_trigger_top #(
        .PERIOD_BEATS (8)
    ) dut0 (.*);

    initial wbclk = 1'b0;
    always #10 wbclk = ~wbclk;

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Error at time %0t: %s is %h, expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "Run aborted");
    endtask

    task automatic wait_drain();
        int waited;
        for (waited = 0; waited < TIMEOUT; waited++) begin
            if (got_cnt == sent_cnt) break;
            @(negedge wbclk);
        end
        if (waited == TIMEOUT) abort_run("Timeout while waiting for the trigger stream to drain");
        repeat (3) @(negedge wbclk);   // Let a period-end correction land
    endtask

    task automatic send_beat(input logic [NCHAN*SAMPLE_W-1:0] data, input logic [NBEAMS-1:0] exp);
        int waited;
        exp_q.push_back(exp);
        sent_cnt++;
        @(negedge wbclk);
        sample_valid_i = 1'b1;
        sample_data_i  = data;
        for (waited = 0; waited < TIMEOUT; waited++) begin
            @(posedge wbclk);
            if (sample_ready_o) break;
        end
        if (waited == TIMEOUT) abort_run("Timeout while waiting for a sample beat to be accepted");
        @(negedge wbclk);
        sample_valid_i = 1'b0;
    endtask

    task automatic reg_access(input logic write, input logic [REG_ADDR_W-1:0] addr,
                              input logic [31:0] data, input logic [31:0] exp);
        int waited;
        reg_word_u got;
        reg_word_u want;
        wait_drain();
        @(negedge wbclk);
        reg_valid_i = 1'b1;
        reg_write_i = write;
        reg_addr_i  = addr;
        reg_wdata_i = data;
        for (waited = 0; waited < TIMEOUT; waited++) begin
            @(posedge wbclk);
            if (reg_ready_o) break;
        end
        if (waited == TIMEOUT) abort_run("Timeout while waiting for a register request to be taken");
        @(negedge wbclk);
        reg_valid_i = 1'b0;
        for (waited = 0; waited < TIMEOUT; waited++) begin
            @(posedge wbclk);
            if (rsp_valid_o && rsp_ready_i) break;
        end
        if (waited == TIMEOUT) abort_run("Timeout while waiting for a register response");
        got  = rsp_rdata_o;
        want = exp;
        if (!write && (addr == ADDR_THRESH0 || addr == ADDR_THRESH1)) begin
            check_value(32'(got.thresh.value), 32'(want.thresh.value), "threshold value");
        end else if (!write && addr == ADDR_SERVO_CFG) begin
            check_value(32'(got.cfg.enable), 32'(want.cfg.enable), "servo enable");
            check_value(32'(got.cfg.kp), 32'(want.cfg.kp), "servo kp");
            check_value(32'(got.cfg.margin), 32'(want.cfg.margin), "servo margin");
            check_value(32'(got.cfg.target), 32'(want.cfg.target), "servo target");
        end
        check_value(got, want, $sformatf("response of address %0d", addr));
    endtask

    // Words leave on an edge with valid and ready both high
    always @(posedge wbclk) begin
        if (rst_n_i && trig_valid_o && trig_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("A trigger word arrived with no sample beat left to match it");
                $display("Regression failed");
                $fatal(1, "Extra trigger word");
            end else begin
                check_value(32'(trig_beams_o), 32'(exp_q.pop_front()),
                            $sformatf("trigger word %0d", got_cnt));
                got_cnt++;
            end
        end
    end

    // Random back-pressure on both response sides
    initial begin
        int seed_ret;
        seed_ret     = $urandom(69835);
        trig_ready_i = 1'b1;
        rsp_ready_i  = 1'b1;
        forever begin
            @(negedge wbclk);
            trig_ready_i = ($urandom % 4) != 0;   // Stall about one cycle in four
            rsp_ready_i  = ($urandom % 3) != 0;
        end
    end

    initial begin
        int fd;
        int n;
        int ch;
        logic [7:0] kind;
        logic [31:0] v0, v1, v2, v3, v4;
        sample_valid_i = 1'b0;
        sample_data_i  = '0;
        reg_valid_i    = 1'b0;
        reg_write_i    = 1'b0;
        reg_addr_i     = '0;
        reg_wdata_i    = '0;
        rst_n_i        = 1'b0;
        repeat (10) @(negedge wbclk);
        rst_n_i = 1'b1;
        fd = $fopen("sim/l1_trigger_input.txt", "r");
        if (fd == 0) abort_run("Could not open sim/l1_trigger_input.txt");
        while ($fscanf(fd, " %c", kind) == 1) begin
            case (kind)
                "#": begin
                    ch = $fgetc(fd);
                    while (ch != "\n" && ch != -1) ch = $fgetc(fd);
                end
                "W", "R": begin
                    n = $fscanf(fd, "%h %h", v0, v1);
                    if (n != 2) abort_run("Register line in the data file is malformed");
                    if (kind == "W") reg_access(1'b1, v0[REG_ADDR_W-1:0], v1, v1);
                    else reg_access(1'b0, v0[REG_ADDR_W-1:0], '0, v1);
                end
                "S": begin
                    n = $fscanf(fd, "%h %h %h %h %h", v0, v1, v2, v3, v4);
                    if (n != 5) abort_run("Sample line in the data file is malformed");
                    send_beat({v3[11:0], v2[11:0], v1[11:0], v0[11:0]}, v4[NBEAMS-1:0]);
                end
                default: abort_run("Unknown operation in the data file");
            endcase
        end
        $fclose(fd);
        wait_drain();
        if (got_cnt == sent_cnt && exp_q.size() == 0) begin
            $display("Regression passed");
            $finish;
        end else begin
            $display("The trigger stream ended short of the sample beats sent");
            $display("Regression failed");
            $fatal(1, "Incomplete trigger stream");
        end
    end

endmodule

`default_nettype wire

/* l1_trigger_top.f */
source/l1_trigger_pkg.sv
source/beam_power.sv
source/threshold_servo.sv
source/trigger_decide.sv
source/l1_trigger_top.sv
sim/l1_trigger_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = l1_trigger_tb
FILELIST = l1_trigger_top.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Regression passed"

clean:
	rm -rf $(OBJ_DIR)

/* sim/l1_trigger_input.txt */
# W addr data: register write | R addr expected: register read (all hex)
# S ch0 ch1 ch2 ch3 word: one sample beat, 12-bit samples, expected trigger word
# Reset values, then flush the delay lines
R 0 0FFFFFFF
R 4 00000000
R 5 00000000
S 7FF 7FF 7FF 7FF 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
# Fixed thresholds, pulse staggered for beam 1, then against it
W 0 00000BB8
W 1 00004E20
S 014 014 014 014 1
S 000 000 000 032 0
S 000 000 032 000 0
S 000 032 000 000 0
S 032 000 000 000 2
S 032 000 000 000 0
S 000 032 000 000 0
S 000 000 032 000 0
S 000 000 000 032 0
S 028 028 028 028 1
S 028 028 028 028 1
S 028 028 028 028 3
R 5 00000002
R 0 00000BB8
# Servo on with target 2, margin 1, kp 16, every beat triggers
W 4 80100102
R 4 80100102
S 028 028 028 028 3
S 028 028 028 028 3
S 028 028 028 028 3
S 028 028 028 028 3
S 028 028 028 028 3
S 028 028 028 028 3
S 028 028 028 028 3
S 028 028 028 028 3
R 0 00000BC8
R 1 00004E30
R 5 00000003
# Quiet period lowers both, beam 0 clamps at zero
W 0 0000000A
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
R 0 00000000
R 1 00004E20
# Servo off, thresholds hold across a period
W 4 00100102
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
S 000 000 000 000 0
R 1 00004E20
R 5 00000005
# Unused and read-only addresses, threshold upper bits
R 2 00000000
W 3 12345678
R 3 00000000
W 5 00000055
R 5 00000005
W 1 F0000123
R 1 00000123
